// ==== files.f ====
hdl/tag_mem_pkg.sv
hdl/select_eval.sv
hdl/tag_state_regs.sv
hdl/mem_access_seq.sv
hdl/tx_serializer.sv
hdl/tag_mem_top.sv
sim/sram_model.sv
sim/tb_tag_mem.sv

// ==== Makefile ====
# Verilator build and run for the tag memory controller testbench

VERILATOR ?= verilator
TOP       ?= tb_tag_mem
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_tag_mem.sv ====
// fixed-seed LFSR stimulus, short tx_done hold of 40 cycles, data_clk driven by the test sequence
`timescale 1ns/1ps

module tb_tag_mem import tag_mem_pkg::*; ();

    localparam int TX_HOLD   = 40;
    localparam int N_EPC     = 8;
    localparam int N_SENS    = 8;
    localparam int N_SEL     = 24;
    localparam int RD_PTR    = 1;
    localparam int RD_WORDS  = 4;
    localparam int DCLK_HALF = 8;
    localparam int WRITE_CYC = 16; // strobe, four phases, quiet checks
    localparam int TEST_CYC  = 10 + (N_EPC + N_SENS + 2) * WRITE_CYC + N_SEL * 2
                               + (RD_WORDS * WORD_W + 2) * 2 * DCLK_HALF + TX_HOLD;
    localparam int WATCHDOG_NS = (TEST_CYC + 500) * 10;

    logic              clk;
    logic              reset;
    rx_req_t           rx;
    sel_cmd_t          sel;
    logic [WORD_W-1:0] epc_data;
    logic              epc_data_ready;
    sample_t           sample;
    logic              adc_data_ready;
    logic [2:0]        sensor_code;
    logic [WORD_W-1:0] mem_read;
    logic              data_clk;
    logic              tx_enable;
    mem_ctrl_t         mem_bus;
    logic              mem_done;
    logic              tx_bit;
    logic              tx_done;
    logic [1:0]        session;
    logic              inven_flag;
    logic              sl_flag;

    logic [31:0]       lfsr;
    logic [WORD_W-1:0] exp_epc [64];
    logic [ADDR_W-1:0] epc_fill;
    logic [ADDR_W-1:0] s1_fill;
    logic [ADDR_W-1:0] s2_fill;

    tag_mem_top #(
        .TX_DONE_HOLD (TX_HOLD)
    ) UUT (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .sel            (sel),
        .epc_data       (epc_data),
        .epc_data_ready (epc_data_ready),
        .sample         (sample),
        .adc_data_ready (adc_data_ready),
        .sensor_code    (sensor_code),
        .mem_read       (mem_read),
        .data_clk       (data_clk),
        .tx_enable      (tx_enable),
        .mem            (mem_bus),
        .mem_done       (mem_done),
        .tx_bit         (tx_bit),
        .tx_done        (tx_done),
        .session        (session),
        .inven_flag     (inven_flag),
        .sl_flag        (sl_flag)
    );

    sram_model u_sram (
        .clk   (clk),
        .mem   (mem_bus),
        .rdata (mem_read)
    );

    always #5 clk = ~clk;

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
                fail_run();
            end
    endtask

    // we/se must follow a precharge cycle directly
    assert property (@(posedge clk) disable iff (reset)
        $fell(mem_bus.pc_b) |=> (mem_bus.we || mem_bus.se))
        else begin
            $display("mismatch at %0t: mem.we|se got %b expected 1", $time,
                     mem_bus.we || mem_bus.se);
            fail_run();
        end

    assert property (@(posedge clk) disable iff (reset) mem_done |=> !mem_done)
        else begin
            $display("mismatch at %0t: mem_done got %b expected 0", $time, mem_done);
            fail_run();
        end

    assert property (@(posedge clk) disable iff (reset) mem_bus.we |-> !mem_bus.se)
        else begin
            $display("mismatch at %0t: mem.se got %b expected 0", $time, mem_bus.se);
            fail_run();
        end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // flag update from the select action table
    function automatic logic apply_select_action(input logic match, input logic [2:0] action,
                                                 input logic cur);
        logic r;
        r = cur;
        if (match) begin
            if (action == 3'd0 || action == 3'd1)
                r = 1'b1;
            else if (action == 3'd4 || action == 3'd5)
                r = 1'b0;
            else if (action == 3'd3)
                r = !cur;
        end else begin
            if (action == 3'd4 || action == 3'd6)
                r = 1'b1;
            else if (action == 3'd0 || action == 3'd2)
                r = 1'b0;
            else if (action == 3'd7)
                r = !cur;
        end
        return r;
    endfunction

    task automatic send_packet(input logic [CMD_W-1:0] cmd, input logic [7:0] ptr,
                               input logic [7:0] words);
        rx.packet_complete = 1'b1;
        rx.rx_cmd          = cmd;
        rx.bank            = BANK_EPC;
        rx.ptr             = ptr;
        rx.words           = words;
        step_cycle();
        rx = '0;
    endtask

    task automatic wait_precharge();
        int n;
        n = 0;
        while (mem_bus.pc_b) begin
            if (n == 8) begin
                $display("no SRAM precharge within 8 cycles of a write request at %0t", $time);
                fail_run();
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic expect_write(input logic [2:0] bank_sel, input logic [ADDR_W-1:0] addr,
                                input logic [WORD_W-1:0] data);
        wait_precharge();
        check_val("mem.sel", 32'(mem_bus.sel), 32'(bank_sel));
        check_val("mem.addr", 32'(mem_bus.addr), 32'(addr));
        step_cycle();
        check_val("mem.we", 32'(mem_bus.we), 32'd1);
        check_val("mem.wdata", 32'(mem_bus.wdata), 32'(data));
        step_cycle();
        check_val("mem_done", 32'(mem_done), 32'd1);
        step_cycle();
        check_val("mem.we", 32'(mem_bus.we), 32'd0); // release
        check_val("mem_done", 32'(mem_done), 32'd0);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            step_cycle();
            check_val("mem.pc_b", 32'(mem_bus.pc_b), 32'd1);
        end
    endtask

    task automatic log_sample(input logic [2:0] code);
        logic [31:0]       r;
        logic [WORD_W-1:0] word;
        rand_bits(16, r);
        sample.stamp   = r[15:8];
        sample.adc     = r[7:0];
        word           = {sample.stamp, sample.adc};
        sensor_code    = code;
        adc_data_ready = 1'b1;
        step_cycle();
        if (code == 3'd1) begin
            expect_write(SEL_S1, s1_fill, word);
            s1_fill = s1_fill + 6'd1;
        end else if (code == 3'd2) begin
            expect_write(SEL_S2, s2_fill, word);
            s2_fill = s2_fill + 6'd1;
        end else begin
            check_val("mem.pc_b", 32'(mem_bus.pc_b), 32'd1);
        end
        expect_quiet(4); // level still high
        adc_data_ready = 1'b0;
        step_cycle();
    endtask

    task automatic dclk_period(output logic bit_seen);
        data_clk = 1'b1;
        repeat (DCLK_HALF) step_cycle();
        bit_seen = tx_bit;
        data_clk = 1'b0;
        repeat (DCLK_HALF) step_cycle();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        fail_run();
    end

    initial begin
        logic [31:0]       r;
        logic [WORD_W-1:0] code;
        logic              is_match;
        logic              exp_inven;
        logic              exp_sl;
        logic [1:0]        exp_session;
        logic [ADDR_W-1:0] rd_addr;
        logic [3:0]        bit_idx;
        logic              bit_seen;
        int                n;
        clk            = 1'b0;
        reset          = 1'b1;
        rx             = '0;
        sel            = '0;
        epc_data       = '0;
        epc_data_ready = 1'b0;
        sample         = '0;
        adc_data_ready = 1'b0;
        sensor_code    = 3'd0;
        data_clk       = 1'b0;
        tx_enable      = 1'b0;
        lfsr           = 32'h9fb76e0d;
        epc_fill       = '0;
        s1_fill        = '0;
        s2_fill        = '0;
        exp_inven      = 1'b1;
        exp_sl         = 1'b1;
        exp_session    = 2'd0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_val("mem.pc_b", 32'(mem_bus.pc_b), 32'd1);
        check_val("mem.we", 32'(mem_bus.we), 32'd0);
        check_val("mem.se", 32'(mem_bus.se), 32'd0);
        check_val("mem_done", 32'(mem_done), 32'd0);
        check_val("tx_bit", 32'(tx_bit), 32'd0);
        check_val("tx_done", 32'(tx_done), 32'd0);
        check_val("inven_flag", 32'(inven_flag), 32'd1);
        check_val("sl_flag", 32'(sl_flag), 32'd1);
        check_val("session", 32'(session), 32'd0);

        tx_enable = 1'b1;
        step_cycle();

        // EPC fill from address 0
        send_packet(CMD_W'(1) << CMD_BIT_WRITE, 8'd0, 8'd0);
        for (int i = 0; i < N_EPC; i++) begin
            rand_bits(16, r);
            epc_data       = r[15:0];
            epc_data_ready = 1'b1;
            step_cycle();
            epc_data_ready = 1'b0;
            expect_write(SEL_EPC, epc_fill, r[15:0]);
            exp_epc[epc_fill] = r[15:0];
            epc_fill = epc_fill + 6'd1;
        end

        for (int i = 0; i < N_SENS; i++)
            log_sample(i[0] ? 3'd2 : 3'd1);
        log_sample(3'd3);

        code = exp_epc[CODE_WORD_ADDR];
        for (int i = 0; i < N_SEL; i++) begin
            rand_bits(1, r);
            is_match = r[0];
            rand_bits(16, r);
            sel.mask = is_match ? code : r[15:0];
            rand_bits(3, r);
            sel.action = r[2:0];
            rand_bits(3, r);
            sel.target = r[2:0];
            is_match = (sel.mask == code);
            if (sel.target < 3'd4) begin
                exp_session = sel.target[1:0];
                exp_inven   = apply_select_action(is_match, sel.action, exp_inven);
            end else if (sel.target == 3'd4) begin
                exp_sl = apply_select_action(is_match, sel.action, exp_sl);
            end
            send_packet(CMD_W'(1) << CMD_BIT_SELECT, 8'd0, 8'd0);
            check_val("session", 32'(session), 32'(exp_session));
            check_val("inven_flag", 32'(inven_flag), 32'(exp_inven));
            check_val("sl_flag", 32'(sl_flag), 32'(exp_sl));
        end

        // read back from the top address down
        send_packet(CMD_W'(1) << CMD_BIT_READ, 8'(RD_PTR), 8'(RD_WORDS));
        dclk_period(bit_seen); // first rise only fetches
        for (int w = 0; w < RD_WORDS; w++) begin
            rd_addr = 6'(RD_PTR + RD_WORDS - 1 - w);
            for (int b = WORD_W - 1; b >= 0; b--) begin
                dclk_period(bit_seen);
                bit_idx = 4'(b);
                check_val("tx_bit", 32'(bit_seen), 32'(exp_epc[rd_addr][bit_idx]));
            end
        end

        data_clk = 1'b1;
        n = 0;
        step_cycle();
        while (!tx_done) begin
            if (n == 2 * DCLK_HALF) begin
                $display("tx_done did not rise after the last bit at %0t", $time);
                fail_run();
            end
            step_cycle();
            n++;
        end
        check_val("tx_bit", 32'(tx_bit), 32'd0);
        data_clk = 1'b0;
        n = 0;
        while (tx_done) begin
            if (n > TX_HOLD) begin
                $display("tx_done stayed high past %0d cycles at %0t", TX_HOLD, $time);
                fail_run();
            end
            n++;
            step_cycle();
        end
        check_val("tx_done high cycles", 32'(n), 32'(TX_HOLD));

        tx_enable = 1'b0;
        step_cycle();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim/sram_model.sv ====
// behavioral SRAM, 3 banks of 64 words; reads and writes only count after a precharge cycle
`timescale 1ns/1ps

module sram_model import tag_mem_pkg::*; (
    input  logic              clk,
    input  mem_ctrl_t         mem,
    output logic [WORD_W-1:0] rdata
);

    logic [WORD_W-1:0] store [3][64];
    logic              precharged = 1'b0;
    logic [1:0]        bank;
    logic              bank_ok;

    initial begin
        for (int i = 0; i < 192; i++)
            store[i[7:6]][i[5:0]] = {8'hc3, i[7:0]}; // bank and address in the fill
    end

    always_comb begin
        bank_ok = 1'b1;
        case (mem.sel)
            SEL_EPC: bank = 2'd0;
            SEL_S1:  bank = 2'd1;
            SEL_S2:  bank = 2'd2;
            default: begin
                bank    = 2'd0;
                bank_ok = 1'b0;
            end
        endcase
    end

    always @(posedge clk) begin
        if (!mem.pc_b)
            precharged <= 1'b1;
        else if (!mem.we && !mem.se)
            precharged <= 1'b0; // released
        if (mem.pc_b && mem.we && precharged && bank_ok)
            store[bank][mem.addr] <= mem.wdata;
    end

    // sense amps drive only during se
    assign rdata = (mem.pc_b && mem.se && precharged && bank_ok) ? store[bank][mem.addr] : '0;

endmodule

// ==== hdl/tag_mem_top.sv ====
// tx_enable must stay high through a write or read sequence, dropping it clears latched commands
`timescale 1ns/1ps

module tag_mem_top import tag_mem_pkg::*; #(
    parameter int TX_DONE_HOLD = 100
) (
    input  logic              clk,
    input  logic              reset,
    input  rx_req_t           rx,
    input  sel_cmd_t          sel,
    input  logic [WORD_W-1:0] epc_data,
    input  logic              epc_data_ready,
    input  sample_t           sample,
    input  logic              adc_data_ready,
    input  logic [2:0]        sensor_code,
    input  logic [WORD_W-1:0] mem_read,
    input  logic              data_clk,
    input  logic              tx_enable,
    output mem_ctrl_t         mem,
    output logic              mem_done,
    output logic              tx_bit,
    output logic              tx_done,
    output logic [1:0]        session,
    output logic              inven_flag,
    output logic              sl_flag
);

    logic [WORD_W-1:0] code_word;
    logic [ADDR_W-1:0] epc_count;
    logic [ADDR_W-1:0] s1_count;
    logic [ADDR_W-1:0] s2_count;
    logic              commit;
    access_op_t        op;
    logic              sensor2;
    logic              word_req;
    logic              word_load;
    logic [WORD_W-1:0] load_word;
    logic              last_word;
    logic              read_active;

    select_eval u_select (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .sel        (sel),
        .code_word  (code_word),
        .session    (session),
        .inven_flag (inven_flag),
        .sl_flag    (sl_flag)
    );

    tag_state_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .commit    (commit),
        .op        (op),
        .sensor2   (sensor2),
        .wdata     (mem.wdata),
        .epc_count (epc_count),
        .s1_count  (s1_count),
        .s2_count  (s2_count),
        .code_word (code_word)
    );

    mem_access_seq u_seq (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .epc_data       (epc_data),
        .epc_data_ready (epc_data_ready),
        .sample         (sample),
        .adc_data_ready (adc_data_ready),
        .sensor_code    (sensor_code),
        .tx_enable      (tx_enable),
        .word_req       (word_req),
        .mem_read       (mem_read),
        .epc_count      (epc_count),
        .s1_count       (s1_count),
        .s2_count       (s2_count),
        .mem            (mem),
        .mem_done       (mem_done),
        .commit         (commit),
        .op             (op),
        .sensor2        (sensor2),
        .word_load      (word_load),
        .load_word      (load_word),
        .last_word      (last_word),
        .read_active    (read_active)
    );

    tx_serializer #(
        .TX_DONE_HOLD (TX_DONE_HOLD)
    ) u_tx (
        .clk         (clk),
        .reset       (reset),
        .data_clk    (data_clk),
        .tx_enable   (tx_enable),
        .read_active (read_active),
        .word_load   (word_load),
        .load_word   (load_word),
        .last_word   (last_word),
        .word_req    (word_req),
        .tx_bit      (tx_bit),
        .tx_done     (tx_done)
    );

endmodule

// ==== hdl/tx_serializer.sv ====
// data_clk must be synchronous to clk with a half period of 8+ cycles so a fetch fits between rises
`timescale 1ns/1ps

module tx_serializer import tag_mem_pkg::*; #(
    parameter int TX_DONE_HOLD = 100
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              data_clk,
    input  logic              tx_enable,
    input  logic              read_active,
    input  logic              word_load,
    input  logic [WORD_W-1:0] load_word,
    input  logic              last_word,
    output logic              word_req,
    output logic              tx_bit,
    output logic              tx_done
);

    localparam int HOLD_W = $clog2(TX_DONE_HOLD + 1);
    localparam int CNT_W  = $clog2(WORD_W);

    logic              dclk_prev;
    logic              rise;
    logic              started;
    logic              valid;
    logic              tail;
    logic              last_q;
    logic [CNT_W-1:0]  bit_cnt;
    logic [WORD_W-1:0] shift;
    logic [HOLD_W-1:0] hold_cnt;

    assign rise = data_clk && !dclk_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            dclk_prev <= 1'b0;
            started   <= 1'b0;
            valid     <= 1'b0;
            tail      <= 1'b0;
            bit_cnt   <= '0;
            word_req  <= 1'b0;
            tx_bit    <= 1'b0;
            tx_done   <= 1'b0;
            hold_cnt  <= '0;
        end else begin
            dclk_prev <= data_clk;
            word_req  <= 1'b0;

            if (tx_done) begin
                if (hold_cnt == HOLD_W'(TX_DONE_HOLD - 1))
                    tx_done <= 1'b0;
                else
                    hold_cnt <= hold_cnt + 1'b1;
            end

            if (!tx_enable) begin
                started <= 1'b0; // back to idle
                valid   <= 1'b0;
                tail    <= 1'b0;
                tx_bit  <= 1'b0;
            end else if (rise) begin
                if (tail) begin
                    tail     <= 1'b0;
                    tx_bit   <= 1'b0;
                    tx_done  <= 1'b1;
                    hold_cnt <= '0;
                end else if (valid) begin
                    tx_bit  <= shift[WORD_W-1];
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(WORD_W - 1)) begin
                        valid <= 1'b0;
                        if (last_q)
                            tail <= 1'b1;
                        else
                            word_req <= 1'b1; // next word lands before next rise
                    end
                end else if (!started && read_active) begin
                    started  <= 1'b1;
                    word_req <= 1'b1;
                end
            end else if (word_load) begin
                valid   <= 1'b1;
                bit_cnt <= '0;
            end
        end
    end

    // shift register payload
    always_ff @(posedge clk) begin
        if (word_load) begin
            shift  <= load_word;
            last_q <= last_word;
        end else if (rise && valid) begin
            shift <= shift << 1;
        end
    end

endmodule

// ==== hdl/mem_access_seq.sv ====
// one 4-cycle access in flight and one pending request per source; extra strobes are dropped
`timescale 1ns/1ps

module mem_access_seq import tag_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  rx_req_t           rx,
    input  logic [WORD_W-1:0] epc_data,
    input  logic              epc_data_ready,
    input  sample_t           sample,
    input  logic              adc_data_ready,
    input  logic [2:0]        sensor_code,
    input  logic              tx_enable,
    input  logic              word_req,
    input  logic [WORD_W-1:0] mem_read,
    input  logic [ADDR_W-1:0] epc_count,
    input  logic [ADDR_W-1:0] s1_count,
    input  logic [ADDR_W-1:0] s2_count,
    output mem_ctrl_t         mem,
    output logic              mem_done,
    output logic              commit,
    output access_op_t        op,
    output logic              sensor2,
    output logic              word_load,
    output logic [WORD_W-1:0] load_word,
    output logic              last_word,
    output logic              read_active
);

    phase_t            phase;
    logic              write_armed;
    logic              read_latched;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] rd_low;
    logic [7:0]        rd_top;
    logic              rd_pend;
    logic              epc_pend;
    logic              s_pend;
    logic [WORD_W-1:0] epc_hold;
    sample_t           s_hold;
    logic              s2_hold;
    logic              adc_prev;
    logic              adc_rise;
    logic              s_valid;
    logic              rd_req;
    logic              epc_req;
    logic              s_req;
    logic              idle;
    logic              start_rd;
    logic              start_epc;
    logic              start_s;
    logic              cap_read;
    logic              cap_write;
    logic              is_write;
    logic              in_drive;
    logic [2:0]        cur_sel;
    logic [ADDR_W-1:0] cur_addr;
    logic [WORD_W-1:0] cur_wdata;

    assign cap_read  = rx.packet_complete && rx.rx_cmd[CMD_BIT_READ] && (rx.bank == BANK_EPC);
    assign cap_write = rx.packet_complete && rx.rx_cmd[CMD_BIT_WRITE] && (rx.bank == BANK_EPC);
    assign rd_top    = rx.ptr + rx.words - 8'd1;

    assign adc_rise = adc_data_ready && !adc_prev;
    assign s_valid  = (sensor_code == 3'd1) || (sensor_code == 3'd2);

    // live strobes count as requests in their own cycle
    assign rd_req  = rd_pend || word_req;
    assign epc_req = epc_pend || (epc_data_ready && write_armed);
    assign s_req   = s_pend || (adc_rise && s_valid);

    assign idle      = (op == OP_IDLE);
    assign start_rd  = idle && rd_req && read_latched;
    assign start_epc = idle && !start_rd && epc_req;
    assign start_s   = idle && !start_rd && !epc_req && s_req;

    // command capture
    always_ff @(posedge clk) begin
        if (reset) begin
            write_armed  <= 1'b0;
            read_latched <= 1'b0;
            rd_addr      <= '0;
            rd_low       <= '0;
        end else begin
            if (cap_write)
                write_armed <= 1'b1;
            else if (!tx_enable)
                write_armed <= 1'b0;

            if (cap_read) begin
                read_latched <= 1'b1;
                rd_addr      <= rd_top[ADDR_W-1:0];
                rd_low       <= rx.ptr[ADDR_W-1:0];
            end else if (!tx_enable) begin
                read_latched <= 1'b0;
            end else if (start_rd) begin
                rd_addr <= rd_addr - 1'b1; // walk down the range
            end
        end
    end

    // one pending request per source
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend  <= 1'b0;
            epc_pend <= 1'b0;
            s_pend   <= 1'b0;
            adc_prev <= 1'b0;
        end else begin
            adc_prev <= adc_data_ready;
            rd_pend  <= rd_req && !start_rd && tx_enable;
            epc_pend <= epc_req && !start_epc;
            s_pend   <= s_req && !start_s;
        end
    end

    always_ff @(posedge clk) begin
        if (epc_data_ready && !epc_pend)
            epc_hold <= epc_data;
        if (adc_rise && !s_pend) begin
            s_hold  <= sample;
            s2_hold <= (sensor_code == 3'd2);
        end
    end

    // access sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            op        <= OP_IDLE;
            phase     <= PH_PRECHARGE;
            cur_sel   <= '0;
            cur_addr  <= '0;
            sensor2   <= 1'b0;
            last_word <= 1'b0;
        end else if (idle) begin
            phase <= PH_PRECHARGE;
            if (start_rd) begin
                op        <= OP_EPC_READ;
                cur_sel   <= SEL_EPC;
                cur_addr  <= rd_addr;
                last_word <= (rd_addr == rd_low);
            end else if (start_epc) begin
                op       <= OP_EPC_WRITE;
                cur_sel  <= SEL_EPC;
                cur_addr <= epc_count;
            end else if (start_s) begin
                op       <= OP_SENSOR_WRITE;
                sensor2  <= s_pend ? s2_hold : (sensor_code == 3'd2);
                cur_sel  <= (s_pend ? s2_hold : (sensor_code == 3'd2)) ? SEL_S2 : SEL_S1;
                cur_addr <= (s_pend ? s2_hold : (sensor_code == 3'd2)) ? s2_count : s1_count;
            end
        end else begin
            case (phase)
                PH_PRECHARGE: phase <= PH_ACCESS;
                PH_ACCESS:    phase <= PH_COMMIT;
                PH_COMMIT:    phase <= PH_RELEASE;
                default: begin
                    phase <= PH_PRECHARGE;
                    op    <= OP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_epc)
            cur_wdata <= epc_pend ? epc_hold : epc_data;
        else if (start_s)
            cur_wdata <= s_pend ? s_hold : sample;
    end

    assign is_write = (op == OP_EPC_WRITE) || (op == OP_SENSOR_WRITE);
    assign in_drive = (phase == PH_ACCESS) || (phase == PH_COMMIT); // we/se window

    always_comb begin
        mem.pc_b  = !(!idle && phase == PH_PRECHARGE);
        mem.we    = is_write && in_drive;
        mem.se    = (op == OP_EPC_READ) && in_drive;
        mem.sel   = cur_sel;
        mem.addr  = cur_addr;
        mem.wdata = cur_wdata;
    end

    assign commit      = is_write && (phase == PH_COMMIT);
    assign mem_done    = commit;
    assign word_load   = (op == OP_EPC_READ) && (phase == PH_COMMIT);
    assign load_word   = mem_read;
    assign read_active = read_latched;

endmodule

// ==== hdl/tag_state_regs.sv ====
// fill counters wrap at 64 words per bank; code word follows the last write to its EPC address
`timescale 1ns/1ps

module tag_state_regs import tag_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  access_op_t        op,
    input  logic              sensor2,
    input  logic [WORD_W-1:0] wdata,
    output logic [ADDR_W-1:0] epc_count,
    output logic [ADDR_W-1:0] s1_count,
    output logic [ADDR_W-1:0] s2_count,
    output logic [WORD_W-1:0] code_word
);

    always_ff @(posedge clk) begin
        if (reset) begin
            epc_count <= '0;
            s1_count  <= '0;
            s2_count  <= '0;
            code_word <= '0;
        end else if (commit) begin
            case (op)
                OP_EPC_WRITE: begin
                    epc_count <= epc_count + 1'b1;
                    if (epc_count == CODE_WORD_ADDR)
                        code_word <= wdata; // word just written there
                end
                OP_SENSOR_WRITE: begin
                    if (sensor2)
                        s2_count <= s2_count + 1'b1;
                    else
                        s1_count <= s1_count + 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/select_eval.sv ====
// select is honoured only for the EPC bank and only in the packet_complete cycle; flags reset to 1
`timescale 1ns/1ps

module select_eval import tag_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  rx_req_t           rx,
    input  sel_cmd_t          sel,
    input  logic [WORD_W-1:0] code_word,
    output logic [1:0]        session,
    output logic              inven_flag,
    output logic              sl_flag
);

    logic sel_hit;
    logic match;
    logic act_set;
    logic act_clr;
    logic act_tog;
    logic flag_cur;
    logic flag_new;

    assign sel_hit = rx.packet_complete && rx.rx_cmd[CMD_BIT_SELECT] && (rx.bank == BANK_EPC);
    assign match   = (sel.mask == code_word);

    // action decode differs for matching and non-matching tags
    always_comb begin
        act_set = 1'b0;
        act_clr = 1'b0;
        act_tog = 1'b0;
        if (match) begin
            case (sel.action)
                3'd0, 3'd1: act_set = 1'b1;
                3'd4, 3'd5: act_clr = 1'b1;
                3'd3:       act_tog = 1'b1;
                default:    ;
            endcase
        end else begin
            case (sel.action)
                3'd4, 3'd6: act_set = 1'b1;
                3'd0, 3'd2: act_clr = 1'b1;
                3'd7:       act_tog = 1'b1;
                default:    ;
            endcase
        end
    end

    assign flag_cur = sel.target[2] ? sl_flag : inven_flag; // target 4 picks SL

    always_comb begin
        if (act_set)
            flag_new = 1'b1;
        else if (act_clr)
            flag_new = 1'b0;
        else if (act_tog)
            flag_new = ~flag_cur;
        else
            flag_new = flag_cur;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            session    <= 2'd0;
            inven_flag <= 1'b1;
            sl_flag    <= 1'b1;
        end else if (sel_hit) begin
            if (sel.target < 3'd4) begin
                session    <= sel.target[1:0];
                inven_flag <= flag_new;
            end else if (sel.target == 3'd4) begin
                sl_flag <= flag_new;
            end
        end
    end

endmodule

// ==== hdl/tag_mem_pkg.sv ====
// shared widths, codes and types; only the EPC bank is readable, sensor banks are write-only logs
package tag_mem_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 6;
    localparam int CMD_W  = 14;

    // bit positions in the one-hot command vector
    localparam int CMD_BIT_SELECT = 4;
    localparam int CMD_BIT_READ   = 7;
    localparam int CMD_BIT_WRITE  = 8;

    localparam logic [1:0] BANK_EPC = 2'b01;

    // one-hot sram bank selects
    localparam logic [2:0] SEL_EPC = 3'b001;
    localparam logic [2:0] SEL_S1  = 3'b010;
    localparam logic [2:0] SEL_S2  = 3'b100;

    localparam logic [ADDR_W-1:0] CODE_WORD_ADDR = 6'd2; // select mask compares against this word

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_EPC_WRITE,
        OP_SENSOR_WRITE,
        OP_EPC_READ
    } access_op_t;

    typedef enum logic [1:0] {
        PH_PRECHARGE,
        PH_ACCESS,
        PH_COMMIT,
        PH_RELEASE
    } phase_t;

    typedef struct packed {
        logic             packet_complete;
        logic [CMD_W-1:0] rx_cmd;
        logic [1:0]       bank;
        logic [7:0]       ptr;
        logic [7:0]       words;
    } rx_req_t;

    typedef struct packed {
        logic [2:0]        target;
        logic [2:0]        action;
        logic [WORD_W-1:0] mask;
    } sel_cmd_t;

    typedef struct packed {
        logic              pc_b;
        logic              we;
        logic              se;
        logic [2:0]        sel;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_ctrl_t;

    // stamp lands in the high byte of the sensor word
    typedef struct packed {
        logic [7:0] stamp;
        logic [7:0] adc;
    } sample_t;

endpackage
